/* linkPkg.sv */
package linkPkg;

	// One byte as framed from the serial line
	typedef logic [7:0] linkByte;

	// Bit position inside a frame
	typedef logic [2:0] bitCount;

	// Command codes sent over the network
	typedef enum logic [7:0] {
		cmdHalf       = 8'd1, // Buffer half full
		cmdEighty     = 8'd2, // Buffer at 80 percent
		cmdNinety     = 8'd3, // Buffer at 90 percent
		cmdFull       = 8'd4, // Buffer full
		cmdFlush      = 8'd5, // Empty the station queue
		cmdReadyQuery = 8'd6, // Ready query, no action
		cmdBinary     = 8'd7, // One binary byte follows
		cmdAscii      = 8'd8  // One ASCII byte follows
	} commandCode;

	// What the next received byte means
	typedef enum logic [1:0] {
		fmtCommand,
		fmtBinary,
		fmtAscii
	} dataFormat;

	// Data byte on its way to the control station
	typedef struct packed {
		logic    isAscii; // Set when it came after cmdAscii
		linkByte data;
	} queuedByte;

endpackage

/* scannerPkg.sv */
package scannerPkg;

	// Strobes toward the local scanner
	// Same bit order as the old 2-bit output, flush high and start low
	typedef struct packed {
		logic flush; // Flush if waiting
		logic start; // Start scanning
	} scannerCommand;

	// Queue occupancy, wide enough for a depth of 8
	typedef logic [3:0] queueLevel;

endpackage

/* byteReceiver.sv */
`timescale 1ns/1ps

module byteReceiver (
	input  logic            clk,
	input  logic            rst,
	input  logic            serialIn,
	output linkPkg::linkByte rxByte,
	output logic            rxStrobe
);
	import linkPkg::*;

	linkByte shiftReg;
	bitCount bitCnt;
	logic    frameDone; // Eighth bit has just been shifted in

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shiftReg  <= '0;
			bitCnt    <= '0;
			frameDone <= 1'b0;
			rxStrobe  <= 1'b0;
		end else begin
			shiftReg  <= {shiftReg[6:0], serialIn}; // MSB first
			bitCnt    <= bitCnt + 3'd1; // Free running, wraps every 8
			frameDone <= (bitCnt == 3'd7);
			rxStrobe  <= frameDone;
		end
	end

	// Completed byte is taken one edge after the counter wraps
	always_ff @(posedge clk) begin
		if (frameDone) begin
			rxByte <= shiftReg;
		end
	end

endmodule

/* transferCenter.sv */
`timescale 1ns/1ps

module transferCenter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rxStrobe,
	input  logic                      readyIn,
	input  linkPkg::linkByte          rxByte,
	output logic                      readyOut,
	output scannerPkg::scannerCommand scannerCmd,
	output linkPkg::queuedByte        pushData,
	output logic                      pushStrobe,
	output logic                      flushStrobe,
	output logic                      badCommand
);
	import linkPkg::*;

	// Queue request encoding, one register so push and flush exclude each other
	localparam logic [1:0] OpNone  = 2'd0;
	localparam logic [1:0] OpPush  = 2'd1;
	localparam logic [1:0] OpFlush = 2'd2;

	dataFormat  format;
	logic [1:0] queueOp;

	assign pushStrobe  = (queueOp == OpPush);
	assign flushStrobe = (queueOp == OpFlush);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			format     <= fmtCommand;
			readyOut   <= 1'b0;
			scannerCmd <= '0;
			queueOp    <= OpNone;
			badCommand <= 1'b0;
		end else begin
			scannerCmd <= '0; // Strobes last one cycle
			queueOp    <= OpNone;
			badCommand <= 1'b0;

			if (rxStrobe) begin
				case (format)
					fmtCommand: begin
						case (commandCode'(rxByte))
							cmdHalf: begin
								readyOut         <= 1'b0;
								scannerCmd.flush <= 1'b1;
							end
							cmdEighty, cmdFull: begin
								readyOut <= readyIn;
							end
							cmdNinety: begin
								readyOut         <= readyIn;
								scannerCmd.start <= 1'b1;
							end
							cmdFlush: begin
								queueOp <= OpFlush;
							end
							cmdReadyQuery: begin
								// Accepted, nothing to do
							end
							cmdBinary: begin
								readyOut <= readyIn;
								format   <= fmtBinary;
							end
							cmdAscii: begin
								readyOut <= readyIn;
								format   <= fmtAscii;
							end
							default: begin
								badCommand <= 1'b1; // Code 0 or 9 and up
							end
						endcase
					end
					fmtBinary: begin
						queueOp <= OpPush;
						format  <= fmtCommand;
					end
					fmtAscii: begin
						if (rxByte[7]) begin
							badCommand <= 1'b1; // Not 7-bit ASCII
						end else begin
							queueOp <= OpPush;
						end
						format <= fmtCommand;
					end
					default: begin
						format <= fmtCommand;
					end
				endcase
			end
		end
	end

	// Payload follows the byte that is pushed
	always_ff @(posedge clk) begin
		if (rxStrobe && format != fmtCommand) begin
			pushData.isAscii <= (format == fmtAscii);
			pushData.data    <= rxByte;
		end
	end

endmodule

/* dataQueue.sv */
`timescale 1ns/1ps

module dataQueue #(
	parameter int QueueDepth = 8,
	parameter int LevelWidth = $bits(scannerPkg::queueLevel)
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pushStrobe,
	input  logic                  flushStrobe,
	input  logic                  stationRead,
	input  linkPkg::queuedByte    pushData,
	output linkPkg::queuedByte    stationData,
	output logic                  stationValid,
	output logic                  empty,
	output logic                  full,
	output logic                  overflow,
	output logic [LevelWidth-1:0] queueCount
);
	import linkPkg::*;

	localparam int PtrWidth = $clog2(QueueDepth);

	queuedByte           mem [QueueDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic                doPush;
	logic                doRead;

	assign empty  = (queueCount == '0);
	assign full   = (queueCount == LevelWidth'(QueueDepth));
	assign doPush = pushStrobe && !full && !flushStrobe;
	assign doRead = stationRead && !empty && !flushStrobe; // Flush beats read

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			queueCount   <= '0;
			stationValid <= 1'b0;
			overflow     <= 1'b0;
		end else begin
			stationValid <= doRead;
			overflow     <= pushStrobe && full && !flushStrobe; // Byte is lost
			if (flushStrobe) begin
				wrPtr      <= '0;
				rdPtr      <= '0;
				queueCount <= '0;
			end else begin
				if (doPush) wrPtr <= wrPtr + 1'b1; // Wraps, depth is a power of two
				if (doRead) rdPtr <= rdPtr + 1'b1;
				queueCount <= queueCount + LevelWidth'(doPush) - LevelWidth'(doRead);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData;
		if (doRead) stationData <= mem[rdPtr]; // Head held for the station
	end

endmodule

/* scannerLinkTop.sv */
`timescale 1ns/1ps

module scannerLinkTop #(
	parameter int QueueDepth = 8,
	parameter int LevelWidth = $clog2(QueueDepth) + 1
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      serialIn,
	input  logic                      readyIn,
	input  logic                      stationRead,
	output logic                      readyOut,
	output scannerPkg::scannerCommand scannerCmd,
	output linkPkg::queuedByte        stationData,
	output logic                      stationValid,
	output logic [LevelWidth-1:0]     queueCount,
	output logic                      empty,
	output logic                      full,
	output logic                      badCommand,
	output logic                      overflow
);
	import linkPkg::*;

	linkByte   rxByte;
	logic      rxStrobe;
	queuedByte pushData;
	logic      pushStrobe;
	logic      flushStrobe;

	byteReceiver u_byteReceiver (
		.clk      (clk),
		.rst      (rst),
		.serialIn (serialIn),
		.rxByte   (rxByte),
		.rxStrobe (rxStrobe)
	);

	transferCenter u_transferCenter (
		.clk         (clk),
		.rst         (rst),
		.rxStrobe    (rxStrobe),
		.readyIn     (readyIn),
		.rxByte      (rxByte),
		.readyOut    (readyOut),
		.scannerCmd  (scannerCmd),
		.pushData    (pushData),
		.pushStrobe  (pushStrobe),
		.flushStrobe (flushStrobe),
		.badCommand  (badCommand)
	);

	dataQueue #(
		.QueueDepth (QueueDepth),
		.LevelWidth (LevelWidth)
	) u_dataQueue (
		.clk          (clk),
		.rst          (rst),
		.pushStrobe   (pushStrobe),
		.flushStrobe  (flushStrobe),
		.stationRead  (stationRead),
		.pushData     (pushData),
		.stationData  (stationData),
		.stationValid (stationValid),
		.empty        (empty),
		.full         (full),
		.overflow     (overflow),
		.queueCount   (queueCount)
	);

endmodule

/* scannerLink_assertions.sv */
`timescale 1ns/1ps

module scannerLink_assertions #(
	parameter int QueueDepth = 8,
	parameter int LevelWidth = 4
) (
	input logic                      clk,
	input logic                      rst,
	input scannerPkg::scannerCommand scannerCmd,
	input logic                      pushStrobe,
	input logic                      flushStrobe,
	input logic                      stationValid,
	input logic                      empty,
	input logic [LevelWidth-1:0]     queueCount
);
	int failCount = 0; // Read by the testbench at the end

	scannerCmdExclusive: assert property (@(posedge clk) disable iff (rst)
		!(scannerCmd.flush && scannerCmd.start))
		else begin
			failCount++;
			$error("Scanner start and flush set in the same cycle");
		end

	queueOpExclusive: assert property (@(posedge clk) disable iff (rst)
		!(pushStrobe && flushStrobe))
		else begin
			failCount++;
			$error("Push and flush strobes high together");
		end

	validNeedsData: assert property (@(posedge clk) disable iff (rst)
		stationValid |-> !$past(empty))
		else begin
			failCount++;
			$error("Station data valid after a read of an empty queue");
		end

	countInRange: assert property (@(posedge clk) disable iff (rst)
		queueCount <= LevelWidth'(QueueDepth))
		else begin
			failCount++;
			$error("Queue count above the queue depth");
		end

endmodule

// Strobes from transferCenter and queue state from dataQueue meet in the top
bind scannerLinkTop scannerLink_assertions #(
	.QueueDepth (QueueDepth),
	.LevelWidth (LevelWidth)
) u_assertions (
	.clk          (clk),
	.rst          (rst),
	.scannerCmd   (scannerCmd),
	.pushStrobe   (pushStrobe),
	.flushStrobe  (flushStrobe),
	.stationValid (stationValid),
	.empty        (empty),
	.queueCount   (queueCount)
);

/* tb_scannerLink.sv */
`timescale 1ns/1ps

module tb_scannerLink;
	import linkPkg::*;
	import scannerPkg::*;

	localparam int QueueDepth    = 8;
	localparam int LevelWidth    = $clog2(QueueDepth) + 1;
	localparam int ClockPeriod   = 40;
	localparam int ResetCycles   = 5;
	localparam int DriveDelay    = 2;
	localparam int RandomBytes   = 240;
	localparam int DirectedBytes = 54;
	localparam int TimeoutCycles = (DirectedBytes + RandomBytes) * 8 + ResetCycles + 100;

	localparam linkByte StatusSeq [8]  = '{8'd1, 8'd2, 8'd3, 8'd4, 8'd3, 8'd1, 8'd2, 8'd4};
	localparam linkByte DataSeq   [10] = '{8'd7, 8'hA5, 8'd8, 8'h41, 8'd8, 8'hC3,
		8'd7, 8'h00, 8'd6, 8'd6};
	localparam linkByte BadSeq    [6]  = '{8'd0, 8'd9, 8'hFF, 8'h80, 8'd6, 8'd6};
	localparam linkByte FlushSeq  [7]  = '{8'd8, 8'h30, 8'd7, 8'h31, 8'd7, 8'h32, 8'd5};

	logic                  clk;
	logic                  rst;
	logic                  serialIn;
	logic                  readyIn;
	logic                  stationRead;
	logic                  readyOut;
	scannerCommand         scannerCmd;
	queuedByte             stationData;
	logic                  stationValid;
	logic [LevelWidth-1:0] queueCount;
	logic                  empty;
	logic                  full;
	logic                  badCommand;
	logic                  overflow;

	logic [31:0]   rngState;
	dataFormat     mdlFormat;
	logic          mdlReady;
	scannerCommand mdlCmd;
	logic          mdlBad;
	logic          mdlPush;
	logic          mdlFlush;
	queuedByte     mdlPushData;
	queuedByte     mdlQueue [$];
	logic          mdlValid;
	queuedByte     mdlHead;
	logic          mdlOverflow;
	linkByte       mdlShift;
	int            mdlBitPos;
	linkByte       pendByte;
	int            pendLeft; // Edges until the pending byte is decoded
	int            readMode; // 0 no reads, 1 random reads, 2 read every cycle
	int            errorCount;
	int            checkCount;
	int            testCount;
	int            testErrStart;

	scannerLinkTop #(.QueueDepth(QueueDepth)) u_scannerLinkTop (
		.clk          (clk),
		.rst          (rst),
		.serialIn     (serialIn),
		.readyIn      (readyIn),
		.stationRead  (stationRead),
		.readyOut     (readyOut),
		.scannerCmd   (scannerCmd),
		.stationData  (stationData),
		.stationValid (stationValid),
		.queueCount   (queueCount),
		.empty        (empty),
		.full         (full),
		.badCommand   (badCommand),
		.overflow     (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, actual, expected, $time);
		end
	endtask

	// Queue effect of the strobes decided one edge earlier
	task automatic stepQueue();
		logic wasFull;
		wasFull     = (mdlQueue.size() == QueueDepth);
		mdlValid    = 1'b0;
		mdlOverflow = 1'b0;
		if (mdlFlush) begin
			mdlQueue.delete();
		end else begin
			if (stationRead && mdlQueue.size() > 0) begin
				mdlValid = 1'b1;
				mdlHead  = mdlQueue.pop_front();
			end
			if (mdlPush && wasFull) mdlOverflow = 1'b1; // Dropped even if a read frees a slot
			else if (mdlPush) mdlQueue.push_back(mdlPushData);
		end
	endtask

	task automatic decodeByte(input linkByte value);
		if (mdlFormat == fmtCommand) begin
			case (value)
				8'd1: begin
					mdlReady     = 1'b0;
					mdlCmd.flush = 1'b1;
				end
				8'd2, 8'd4: mdlReady = readyIn;
				8'd3: begin
					mdlReady     = readyIn;
					mdlCmd.start = 1'b1;
				end
				8'd5: mdlFlush = 1'b1;
				8'd6: ; // Query only
				8'd7, 8'd8: begin
					mdlReady  = readyIn;
					mdlFormat = (value == 8'd7) ? fmtBinary : fmtAscii;
				end
				default: mdlBad = 1'b1;
			endcase
		end else begin
			if (mdlFormat == fmtAscii && value[7]) begin
				mdlBad = 1'b1;
			end else begin
				mdlPush     = 1'b1;
				mdlPushData = '{isAscii: (mdlFormat == fmtAscii), data: value};
			end
			mdlFormat = fmtCommand;
		end
	endtask

	// Inputs seen here are the ones the DUT sampled at this edge
	task automatic modelEdge();
		stepQueue();
		mdlCmd   = '0;
		mdlBad   = 1'b0;
		mdlPush  = 1'b0;
		mdlFlush = 1'b0;
		if (pendLeft > 0) begin
			pendLeft--;
			if (pendLeft == 0) decodeByte(pendByte);
		end
		mdlShift = {mdlShift[6:0], serialIn};
		if (mdlBitPos == 7) begin
			pendByte  = mdlShift;
			pendLeft  = 2; // Decision lands two edges after the eighth bit
			mdlBitPos = 0;
		end else begin
			mdlBitPos++;
		end
	endtask

	task automatic compareOutputs();
		checkValue("readyOut", readyOut, mdlReady);
		checkValue("scannerCmd", scannerCmd, mdlCmd);
		checkValue("badCommand", badCommand, mdlBad);
		checkValue("stationValid", stationValid, mdlValid);
		if (mdlValid) checkValue("stationData", stationData, mdlHead);
		checkValue("queueCount", queueCount, mdlQueue.size());
		checkValue("empty", empty, mdlQueue.size() == 0);
		checkValue("full", full, mdlQueue.size() == QueueDepth);
		checkValue("overflow", overflow, mdlOverflow);
	endtask

	task automatic sendByte(input linkByte value);
		logic [31:0] r;
		for (int i = 7; i >= 0; i--) begin
			serialIn = value[i]; // MSB first
			r = lcgNext();
			if (i == 7) readyIn = r[20]; // Ready only moves at byte boundaries
			stationRead = (readMode == 2) || (readMode == 1 && r[18:17] == 2'b00);
			@(posedge clk);
			#1;
			modelEdge();
			compareOutputs();
			#(DriveDelay - 1);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errorCount - testErrStart);
		testErrStart = errorCount;
	endtask

	initial begin
		logic [31:0] r;
		rngState    = 32'd82;
		rst         = 1'b1;
		serialIn    = 1'b0;
		readyIn     = 1'b0;
		stationRead = 1'b0;
		readMode    = 0;
		mdlFormat   = fmtCommand;
		mdlReady    = 1'b0;
		mdlCmd      = '0;
		mdlBad      = 1'b0;
		mdlPush     = 1'b0;
		mdlFlush    = 1'b0;
		mdlValid    = 1'b0;
		mdlOverflow = 1'b0;
		mdlShift    = '0;
		mdlBitPos   = 0;
		pendLeft    = 0;
		errorCount  = 0;
		checkCount  = 0;
		testCount   = 0;
		testErrStart = 0;
		repeat (ResetCycles) @(posedge clk);
		#(DriveDelay);
		compareOutputs(); // Values held by reset
		rst = 1'b0;

		foreach (StatusSeq[i]) sendByte(StatusSeq[i]);
		finishTest("status commands");
		readMode = 2;
		foreach (DataSeq[i]) sendByte(DataSeq[i]);
		finishTest("binary and ASCII data");
		readMode = 0;
		foreach (BadSeq[i]) sendByte(BadSeq[i]);
		finishTest("unknown codes");
		for (int i = 0; i < QueueDepth + 1; i++) begin
			r = lcgNext();
			sendByte(8'd7);
			sendByte(r[23:16]); // Last one hits a full queue
		end
		sendByte(8'd6); // Last push lands here while nothing is read
		readMode = 2;
		sendByte(8'd6);
		sendByte(8'd6); // Drains, then reads on empty
		finishTest("queue order and overflow");
		readMode = 0;
		foreach (FlushSeq[i]) sendByte(FlushSeq[i]);
		readMode = 2;
		sendByte(8'd6);
		finishTest("flush");
		readMode = 1;
		for (int i = 0; i < RandomBytes; i++) begin
			r = lcgNext();
			if (r[25:24] == 2'b00) sendByte(r[15:8]);
			else sendByte(8'd1 + {5'd0, r[10:8]}); // Codes 1 to 8
		end
		sendByte(8'd6);
		finishTest("random traffic");

		errorCount += u_scannerLinkTop.u_assertions.failCount;
		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog sized from the number of bytes sent
	initial begin
		#(TimeoutCycles * ClockPeriod);
		$display("Timeout: the tests did not complete in the expected time");
		$display("Something failed");
		$finish;
	end

endmodule

/* list.f */
linkPkg.sv
scannerPkg.sv
byteReceiver.sv
transferCenter.sv
dataQueue.sv
scannerLinkTop.sv
scannerLink_assertions.sv
tb_scannerLink.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_scannerLink
FILELIST  = list.f
OBJDIR    = obj_dir
RUNFLAGS  = +verilator+error+limit+1000
PASSTEXT  = Everything OK

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
